// File: Makefile
# Verilator build and run of the memory subsystem testbench

TOP := mem_subsystem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the result"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/bmem_arbiter.sv
module bmem_arbiter #(
    parameter int LINE_BEATS = line_pkg::LINE_BEATS_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n_i,

    // instruction cache adapter
    input  bmem_pkg::addr_t     icache_addr_i,
    input  logic                icache_read_i,
    input  logic                icache_write_i,
    input  bmem_pkg::beat_t     icache_wdata_i,
    output logic                icache_ready_o,
    output bmem_pkg::beat_t     icache_rdata_o,
    output logic                icache_rvalid_o,

    // data cache adapter
    input  bmem_pkg::addr_t     dcache_addr_i,
    input  logic                dcache_read_i,
    input  logic                dcache_write_i,
    input  bmem_pkg::beat_t     dcache_wdata_i,
    output logic                dcache_ready_o,
    output bmem_pkg::beat_t     dcache_rdata_o,
    output logic                dcache_rvalid_o,

    // external burst bus
    output bmem_pkg::addr_t     bmem_addr_o,
    output logic                bmem_read_o,
    output logic                bmem_write_o,
    output bmem_pkg::beat_t     bmem_wdata_o,
    input  logic                bmem_ready_i,
    input  bmem_pkg::addr_t     bmem_raddr_i,
    input  bmem_pkg::beat_t     bmem_rdata_i,
    input  logic                bmem_rvalid_i
);

    localparam int CNT_WIDTH = $clog2(LINE_BEATS);
    localparam logic [CNT_WIDTH-1:0] LAST_BEAT = CNT_WIDTH'(LINE_BEATS - 1);

    logic                   busy;
    line_pkg::req_src_e     owner;
    line_pkg::req_src_e     pick;
    line_pkg::req_src_e     cur_src;
    logic [CNT_WIDTH-1:0]   beat_cnt;
    logic                   icache_req;
    logic                   dcache_req;
    logic                   beat_hit;
    logic                   beat_done;

    assign icache_req = icache_read_i | icache_write_i;
    assign dcache_req = dcache_read_i | dcache_write_i;

    // dcache wins a tie from idle
    assign pick    = dcache_req ? line_pkg::REQ_DCACHE : line_pkg::REQ_ICACHE;
    assign cur_src = busy ? owner : pick;

    always_comb begin
        if (cur_src == line_pkg::REQ_DCACHE) begin
            bmem_addr_o  = dcache_addr_i;
            bmem_read_o  = dcache_read_i;
            bmem_write_o = dcache_write_i;
            bmem_wdata_o = dcache_wdata_i;
        end else begin
            bmem_addr_o  = icache_addr_i;
            bmem_read_o  = icache_read_i;
            bmem_write_o = icache_write_i;
            bmem_wdata_o = icache_wdata_i;
        end
    end

    // only beats of the owner's line count
    assign beat_hit  = busy & bmem_rvalid_i & (bmem_raddr_i == bmem_addr_o);
    assign beat_done = (bmem_write_o & bmem_ready_i) | beat_hit;

    assign icache_ready_o  = bmem_ready_i & (cur_src == line_pkg::REQ_ICACHE);
    assign dcache_ready_o  = bmem_ready_i & (cur_src == line_pkg::REQ_DCACHE);
    assign icache_rdata_o  = bmem_rdata_i;
    assign dcache_rdata_o  = bmem_rdata_i;
    assign icache_rvalid_o = beat_hit & (owner == line_pkg::REQ_ICACHE);
    assign dcache_rvalid_o = beat_hit & (owner == line_pkg::REQ_DCACHE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy     <= 1'b0;
            owner    <= line_pkg::REQ_ICACHE;
            beat_cnt <= '0;
        end else if (!busy) begin
            if (icache_req | dcache_req) begin
                busy  <= 1'b1;
                owner <= pick;
            end
            // first write beat may go out in the grant cycle
            if (beat_done) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end else if (beat_done) begin
            if (beat_cnt == LAST_BEAT) begin
                busy     <= 1'b0;
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule : bmem_arbiter

// File: logic/bmem_pkg.sv
package bmem_pkg;

    // byte address on the burst bus
    localparam int ADDR_WIDTH = 32;

    // data bits moved per bus beat
    localparam int BEAT_WIDTH = 64;

    // one bus address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // one bus beat of data
    typedef logic [BEAT_WIDTH-1:0] beat_t;

endpackage : bmem_pkg

// File: logic/line_adapter.sv
module line_adapter #(
    parameter int LINE_BEATS = line_pkg::LINE_BEATS_DEFAULT
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,

    // cache line side
    input  bmem_pkg::addr_t                             line_addr_i,
    input  logic                                        line_read_i,
    input  logic                                        line_write_i,
    input  logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  line_wdata_i,
    output logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  line_rdata_o,
    output logic                                        line_resp_o,

    // burst bus side, towards the arbiter
    output bmem_pkg::addr_t                             bus_addr_o,
    output logic                                        bus_read_o,
    output logic                                        bus_write_o,
    output bmem_pkg::beat_t                             bus_wdata_o,
    input  logic                                        bus_ready_i,
    input  bmem_pkg::beat_t                             bus_rdata_i,
    input  logic                                        bus_rvalid_i
);

    localparam int CNT_WIDTH = $clog2(LINE_BEATS);
    localparam logic [CNT_WIDTH-1:0] LAST_BEAT = CNT_WIDTH'(LINE_BEATS - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_REQ,
        ST_READ_WAIT,
        ST_WRITE_BEATS,
        ST_RESPOND
    } state_e;

    state_e                         state;
    state_e                         state_next;
    logic [CNT_WIDTH-1:0]           beat_cnt;
    logic [CNT_WIDTH-1:0]           beat_cnt_next;

    // line viewed as an array of beats, lowest beat at index 0
    bmem_pkg::beat_t [LINE_BEATS-1:0] wr_beats;
    bmem_pkg::beat_t [LINE_BEATS-1:0] line_buf;

    assign wr_beats = line_wdata_i;

    // requester holds the address until resp, so it goes straight out
    assign bus_addr_o  = line_addr_i;
    assign bus_read_o  = (state == ST_READ_REQ);
    assign bus_write_o = (state == ST_WRITE_BEATS);
    assign bus_wdata_o = wr_beats[beat_cnt];

    assign line_rdata_o = line_buf;
    assign line_resp_o  = (state == ST_RESPOND);

    always_comb begin
        state_next    = state;
        beat_cnt_next = beat_cnt;
        unique case (state)
            ST_IDLE: begin
                beat_cnt_next = '0;
                if (line_read_i) begin
                    state_next = ST_READ_REQ;
                end else if (line_write_i) begin
                    state_next = ST_WRITE_BEATS;
                end
            end
            ST_READ_REQ: begin
                // read pulse is held until the bus takes it
                if (bus_ready_i) begin
                    state_next = ST_READ_WAIT;
                end
            end
            ST_READ_WAIT: begin
                if (bus_rvalid_i) begin
                    beat_cnt_next = beat_cnt + 1'b1;
                    if (beat_cnt == LAST_BEAT) begin
                        state_next = ST_RESPOND;
                    end
                end
            end
            ST_WRITE_BEATS: begin
                // a refused beat stays on the bus unchanged
                if (bus_ready_i) begin
                    beat_cnt_next = beat_cnt + 1'b1;
                    if (beat_cnt == LAST_BEAT) begin
                        state_next = ST_RESPOND;
                    end
                end
            end
            ST_RESPOND: begin
                // request is still high here, ignore it
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            state    <= state_next;
            beat_cnt <= beat_cnt_next;
        end
    end

    // gather read beats into their slot of the line
    always_ff @(posedge clk) begin
        if (state == ST_READ_WAIT && bus_rvalid_i) begin
            line_buf[beat_cnt] <= bus_rdata_i;
        end
    end

endmodule : line_adapter

// File: logic/line_pkg.sv
package line_pkg;

    // 4 beats of 64 bits make a 32-byte cache line
    localparam int LINE_BEATS_DEFAULT = 4;

    // which cache port a bus transaction belongs to
    typedef enum logic {
        REQ_ICACHE = 1'b0,
        REQ_DCACHE = 1'b1
    } req_src_e;

endpackage : line_pkg

// File: logic/mem_subsystem.sv
module mem_subsystem #(
    parameter int LINE_BEATS = line_pkg::LINE_BEATS_DEFAULT
) (
    input  logic                                        clk,
    input  logic                                        rst_n_i,

    // instruction cache line port
    input  bmem_pkg::addr_t                             icache_addr_i,
    input  logic                                        icache_read_i,
    input  logic                                        icache_write_i,
    input  logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  icache_wdata_i,
    output logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  icache_rdata_o,
    output logic                                        icache_resp_o,

    // data cache line port
    input  bmem_pkg::addr_t                             dcache_addr_i,
    input  logic                                        dcache_read_i,
    input  logic                                        dcache_write_i,
    input  logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  dcache_wdata_i,
    output logic [LINE_BEATS*bmem_pkg::BEAT_WIDTH-1:0]  dcache_rdata_o,
    output logic                                        dcache_resp_o,

    // external burst bus
    output bmem_pkg::addr_t                             bmem_addr_o,
    output logic                                        bmem_read_o,
    output logic                                        bmem_write_o,
    output bmem_pkg::beat_t                             bmem_wdata_o,
    input  logic                                        bmem_ready_i,
    input  bmem_pkg::addr_t                             bmem_raddr_i,
    input  bmem_pkg::beat_t                             bmem_rdata_i,
    input  logic                                        bmem_rvalid_i
);

    // adapter to arbiter wiring
    bmem_pkg::addr_t    ic_bus_addr;
    logic               ic_bus_read;
    logic               ic_bus_write;
    bmem_pkg::beat_t    ic_bus_wdata;
    logic               ic_bus_ready;
    bmem_pkg::beat_t    ic_bus_rdata;
    logic               ic_bus_rvalid;

    bmem_pkg::addr_t    dc_bus_addr;
    logic               dc_bus_read;
    logic               dc_bus_write;
    bmem_pkg::beat_t    dc_bus_wdata;
    logic               dc_bus_ready;
    bmem_pkg::beat_t    dc_bus_rdata;
    logic               dc_bus_rvalid;

    line_adapter #(
        .LINE_BEATS (LINE_BEATS)
    ) icache_adapter_inst (
        .clk,
        .rst_n_i,
        .line_addr_i    (icache_addr_i),
        .line_read_i    (icache_read_i),
        .line_write_i   (icache_write_i),
        .line_wdata_i   (icache_wdata_i),
        .line_rdata_o   (icache_rdata_o),
        .line_resp_o    (icache_resp_o),
        .bus_addr_o     (ic_bus_addr),
        .bus_read_o     (ic_bus_read),
        .bus_write_o    (ic_bus_write),
        .bus_wdata_o    (ic_bus_wdata),
        .bus_ready_i    (ic_bus_ready),
        .bus_rdata_i    (ic_bus_rdata),
        .bus_rvalid_i   (ic_bus_rvalid)
    );

    line_adapter #(
        .LINE_BEATS (LINE_BEATS)
    ) dcache_adapter_inst (
        .clk,
        .rst_n_i,
        .line_addr_i    (dcache_addr_i),
        .line_read_i    (dcache_read_i),
        .line_write_i   (dcache_write_i),
        .line_wdata_i   (dcache_wdata_i),
        .line_rdata_o   (dcache_rdata_o),
        .line_resp_o    (dcache_resp_o),
        .bus_addr_o     (dc_bus_addr),
        .bus_read_o     (dc_bus_read),
        .bus_write_o    (dc_bus_write),
        .bus_wdata_o    (dc_bus_wdata),
        .bus_ready_i    (dc_bus_ready),
        .bus_rdata_i    (dc_bus_rdata),
        .bus_rvalid_i   (dc_bus_rvalid)
    );

    bmem_arbiter #(
        .LINE_BEATS (LINE_BEATS)
    ) bmem_arbiter_inst (
        .clk,
        .rst_n_i,
        .icache_addr_i      (ic_bus_addr),
        .icache_read_i      (ic_bus_read),
        .icache_write_i     (ic_bus_write),
        .icache_wdata_i     (ic_bus_wdata),
        .icache_ready_o     (ic_bus_ready),
        .icache_rdata_o     (ic_bus_rdata),
        .icache_rvalid_o    (ic_bus_rvalid),
        .dcache_addr_i      (dc_bus_addr),
        .dcache_read_i      (dc_bus_read),
        .dcache_write_i     (dc_bus_write),
        .dcache_wdata_i     (dc_bus_wdata),
        .dcache_ready_o     (dc_bus_ready),
        .dcache_rdata_o     (dc_bus_rdata),
        .dcache_rvalid_o    (dc_bus_rvalid),
        .bmem_addr_o,
        .bmem_read_o,
        .bmem_write_o,
        .bmem_wdata_o,
        .bmem_ready_i,
        .bmem_raddr_i,
        .bmem_rdata_i,
        .bmem_rvalid_i
    );

endmodule : mem_subsystem

// File: sources.f
logic/bmem_pkg.sv
logic/line_pkg.sv
logic/line_adapter.sv
logic/bmem_arbiter.sv
logic/mem_subsystem.sv
tests/bmem_model.sv
tests/mem_subsystem_tb.sv

// File: tests/bmem_model.sv
module bmem_model #(
    parameter int LINE_BEATS = line_pkg::LINE_BEATS_DEFAULT
) (
    input  logic            clk,
    input  bmem_pkg::addr_t bmem_addr_i,
    input  logic            bmem_read_i,
    input  logic            bmem_write_i,
    input  bmem_pkg::beat_t bmem_wdata_i,
    output logic            bmem_ready_o,
    output bmem_pkg::addr_t bmem_raddr_o,
    output bmem_pkg::beat_t bmem_rdata_o,
    output logic            bmem_rvalid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEAT_BYTES = bmem_pkg::BEAT_WIDTH / 8;

    // sparse storage, one entry per beat address
    bmem_pkg::beat_t mem [bmem_pkg::addr_t];
    logic [31:0]     lfsr;
    int              wr_beat;
    int              rd_beat;
    int              rd_delay;
    logic            rd_busy;
    bmem_pkg::addr_t rd_addr;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // unwritten beats read back as a pattern of their own address
    function automatic bmem_pkg::beat_t read_beat(input bmem_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a, a};
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        lfsr          = 32'h1836_733c;
        wr_beat       = 0;
        rd_beat       = 0;
        rd_delay      = 0;
        rd_busy       = 1'b0;
        rd_addr       = '0;
    end

    always begin
        logic            nxt_valid;
        logic            nxt_ready;
        bmem_pkg::beat_t nxt_data;
        @(negedge clk);
        nxt_valid = 1'b0;
        nxt_data  = '0;
        if (bmem_write_i && bmem_ready_o) begin
            mem[bmem_pkg::addr_t'(bmem_addr_i + BEAT_BYTES * wr_beat)] = bmem_wdata_i;
            wr_beat = (wr_beat + 1) % LINE_BEATS;
        end
        if (bmem_rvalid_o) begin
            rd_beat = rd_beat + 1;
            if (rd_beat == LINE_BEATS) begin
                rd_busy = 1'b0;
            end
        end
        if (bmem_read_i && bmem_ready_o && !rd_busy) begin
            rd_busy  = 1'b1;
            rd_addr  = bmem_addr_i;
            rd_beat  = 0;
            // 2 to 5 idle cycles before the first beat
            rd_delay = 2 + 2 * int'(lfsr[0]);
            lfsr     = lfsr_step(lfsr);
            rd_delay = rd_delay + int'(lfsr[0]);
            lfsr     = lfsr_step(lfsr);
        end
        if (rd_busy) begin
            if (rd_delay > 0) begin
                rd_delay = rd_delay - 1;
            end else begin
                // random gaps between beats
                nxt_valid = lfsr[0];
                lfsr      = lfsr_step(lfsr);
                nxt_data  = read_beat(bmem_pkg::addr_t'(rd_addr + BEAT_BYTES * rd_beat));
            end
        end
        nxt_ready = lfsr[0];
        lfsr      = lfsr_step(lfsr);
        @(posedge clk);
        #1;
        bmem_ready_o  = nxt_ready;
        bmem_rvalid_o = nxt_valid;
        bmem_rdata_o  = nxt_data;
        bmem_raddr_o  = rd_addr;
    end

endmodule : bmem_model

// File: tests/mem_subsystem_tb.sv
module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_BEATS = line_pkg::LINE_BEATS_DEFAULT;
    localparam int LINE_W     = LINE_BEATS * bmem_pkg::BEAT_WIDTH;
    localparam int BEAT_BYTES = bmem_pkg::BEAT_WIDTH / 8;
    localparam int TIMEOUT    = 200;
    localparam int NUM_ROWS   = 15;

    typedef struct packed {
        line_pkg::req_src_e src;
        logic               wr;
        logic               paired;
        bmem_pkg::addr_t    addr;
        logic [31:0]        word;
    } row_t;

    logic               clk;
    logic               rst_n_i;
    bmem_pkg::addr_t    ic_addr;
    bmem_pkg::addr_t    dc_addr;
    logic               ic_read;
    logic               ic_write;
    logic               dc_read;
    logic               dc_write;
    logic [LINE_W-1:0]  ic_wdata;
    logic [LINE_W-1:0]  ic_rdata;
    logic [LINE_W-1:0]  dc_wdata;
    logic [LINE_W-1:0]  dc_rdata;
    logic               ic_resp;
    logic               dc_resp;
    bmem_pkg::addr_t    bmem_addr;
    bmem_pkg::addr_t    bmem_raddr;
    logic               bmem_read;
    logic               bmem_write;
    logic               bmem_ready;
    logic               bmem_rvalid;
    bmem_pkg::beat_t    bmem_wdata;
    bmem_pkg::beat_t    bmem_rdata;

    row_t               rows [NUM_ROWS];
    logic [LINE_W-1:0]  ref_mem [bmem_pkg::addr_t];
    line_pkg::req_src_e done_q [$];
    int                 data_errs;
    int                 order_errs;
    int                 timeouts;

    mem_subsystem #(.LINE_BEATS(LINE_BEATS)) mem_subsystem_inst (
        .clk, .rst_n_i,
        .icache_addr_i(ic_addr), .icache_read_i(ic_read), .icache_write_i(ic_write),
        .icache_wdata_i(ic_wdata), .icache_rdata_o(ic_rdata), .icache_resp_o(ic_resp),
        .dcache_addr_i(dc_addr), .dcache_read_i(dc_read), .dcache_write_i(dc_write),
        .dcache_wdata_i(dc_wdata), .dcache_rdata_o(dc_rdata), .dcache_resp_o(dc_resp),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_write_o(bmem_write),
        .bmem_wdata_o(bmem_wdata), .bmem_ready_i(bmem_ready), .bmem_raddr_i(bmem_raddr),
        .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid)
    );

    bmem_model #(.LINE_BEATS(LINE_BEATS)) bmem_model_inst (
        .clk, .bmem_addr_i(bmem_addr), .bmem_read_i(bmem_read), .bmem_write_i(bmem_write),
        .bmem_wdata_i(bmem_wdata), .bmem_ready_o(bmem_ready), .bmem_raddr_o(bmem_raddr),
        .bmem_rdata_o(bmem_rdata), .bmem_rvalid_o(bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // beat k of a written line derives from the row word
    function automatic logic [LINE_W-1:0] make_line(input logic [31:0] word);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_BEATS; k++) begin
            l[k*64 +: 64] = {word + 32'(k), word ^ (32'h1111_1111 * 32'(k))};
        end
        return l;
    endfunction

    // memory never written holds each beat's own address and its inverse
    function automatic logic [LINE_W-1:0] expected_line(input bmem_pkg::addr_t a);
        logic [LINE_W-1:0] l;
        bmem_pkg::addr_t   b;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        for (int k = 0; k < LINE_BEATS; k++) begin
            b = a + bmem_pkg::addr_t'(BEAT_BYTES * k);
            l[k*64 +: 64] = {~b, b};
        end
        return l;
    endfunction

    task automatic check_line(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                              input bmem_pkg::addr_t a);
        if (got !== exp) begin
            data_errs++;
            $display("[FAIL] %0t ns: line 0x%08h read 0x%0h, expected 0x%0h",
                     $time, a, got, exp);
        end
    endtask

    task automatic check_src(input line_pkg::req_src_e got, input line_pkg::req_src_e exp);
        if (got !== exp) begin
            order_errs++;
            $display("[FAIL] %0t ns: completion from %s, expected %s",
                     $time, got.name(), exp.name());
        end
    endtask

    task automatic drive_port(input row_t r, input logic on);
        if (r.src == line_pkg::REQ_DCACHE) begin
            dc_addr  = r.addr;
            dc_read  = on & ~r.wr;
            dc_write = on & r.wr;
            dc_wdata = make_line(r.word);
        end else begin
            ic_addr  = r.addr;
            ic_read  = on & ~r.wr;
            ic_write = on & r.wr;
            ic_wdata = make_line(r.word);
        end
    endtask

    task automatic finish_row(input row_t r);
        if (r.wr) begin
            ref_mem[r.addr] = make_line(r.word);
        end else if (r.src == line_pkg::REQ_DCACHE) begin
            check_line(dc_rdata, expected_line(r.addr), r.addr);
        end else begin
            check_line(ic_rdata, expected_line(r.addr), r.addr);
        end
    endtask

    // issue one row, or two rows together, and wait for each resp
    task automatic apply_rows(input row_t a, input row_t b, input logic both);
        logic a_done;
        logic b_done;
        logic a_resp;
        logic b_resp;
        int   cyc;
        @(posedge clk);
        #1;
        drive_port(a, 1'b1);
        if (both) begin
            drive_port(b, 1'b1);
        end
        a_done = 1'b0;
        b_done = !both;
        cyc    = 0;
        while (!(a_done && b_done) && cyc < TIMEOUT) begin
            @(negedge clk);
            a_resp = (a.src == line_pkg::REQ_DCACHE) ? dc_resp : ic_resp;
            b_resp = (a.src == line_pkg::REQ_DCACHE) ? ic_resp : dc_resp;
            if (a_resp && !a_done) begin
                a_done = 1'b1;
                done_q.push_back(a.src);
                finish_row(a);
            end
            if (b_resp && both && !b_done) begin
                b_done = 1'b1;
                done_q.push_back(b.src);
                finish_row(b);
            end else if (b_resp && !both) begin
                data_errs++;
                $display("[FAIL] %0t ns: resp on the idle port", $time);
            end
            if (a_resp || (b_resp && both)) begin
                @(posedge clk);
                #1;
                if (a_done) begin
                    drive_port(a, 1'b0);
                end
                if (b_done && both) begin
                    drive_port(b, 1'b0);
                end
            end
            cyc++;
        end
        if (!a_done) begin
            timeouts++;
            $display("requester %s got no response within %0d cycles", a.src.name(), TIMEOUT);
        end
        if (!b_done) begin
            timeouts++;
            $display("requester %s got no response within %0d cycles", b.src.name(), TIMEOUT);
        end
        @(posedge clk);
        #1;
        drive_port(a, 1'b0);
        if (both) begin
            drive_port(b, 1'b0);
        end
    endtask

    initial begin
        line_pkg::req_src_e first;
        line_pkg::req_src_e second;
        rst_n_i  = 1'b0;
        ic_addr  = '0;
        ic_read  = 1'b0;
        ic_write = 1'b0;
        ic_wdata = '0;
        dc_addr  = '0;
        dc_read  = 1'b0;
        dc_write = 1'b0;
        dc_wdata = '0;
        data_errs  = 0;
        order_errs = 0;
        timeouts   = 0;
        // requester, write, paired with next row, line address, data word
        rows[0]  = '{line_pkg::REQ_DCACHE, 1'b0, 1'b0, 32'h0000_0100, 32'h0};
        rows[1]  = '{line_pkg::REQ_DCACHE, 1'b1, 1'b0, 32'h0000_0200, 32'ha5a5_0001};
        rows[2]  = '{line_pkg::REQ_DCACHE, 1'b0, 1'b0, 32'h0000_0200, 32'h0};
        rows[3]  = '{line_pkg::REQ_ICACHE, 1'b0, 1'b0, 32'h0000_0300, 32'h0};
        rows[4]  = '{line_pkg::REQ_DCACHE, 1'b0, 1'b1, 32'h0000_0200, 32'h0};
        rows[5]  = '{line_pkg::REQ_ICACHE, 1'b0, 1'b0, 32'h0000_0100, 32'h0};
        rows[6]  = '{line_pkg::REQ_ICACHE, 1'b1, 1'b0, 32'h0000_0420, 32'h1234_5678};
        rows[7]  = '{line_pkg::REQ_DCACHE, 1'b1, 1'b0, 32'h0000_0440, 32'hdead_0002};
        rows[8]  = '{line_pkg::REQ_DCACHE, 1'b0, 1'b0, 32'h0000_0420, 32'h0};
        rows[9]  = '{line_pkg::REQ_ICACHE, 1'b0, 1'b0, 32'h0000_0440, 32'h0};
        rows[10] = '{line_pkg::REQ_DCACHE, 1'b1, 1'b0, 32'h0000_0420, 32'h0bad_f00d};
        rows[11] = '{line_pkg::REQ_DCACHE, 1'b0, 1'b1, 32'h0000_0420, 32'h0};
        rows[12] = '{line_pkg::REQ_ICACHE, 1'b0, 1'b0, 32'h0000_0200, 32'h0};
        rows[13] = '{line_pkg::REQ_ICACHE, 1'b1, 1'b0, 32'h8000_0fe0, 32'hc001_cafe};
        rows[14] = '{line_pkg::REQ_DCACHE, 1'b0, 1'b0, 32'h8000_0fe0, 32'h0};
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].paired && i + 1 < NUM_ROWS) begin
                done_q.delete();
                apply_rows(rows[i], rows[i+1], 1'b1);
                if (done_q.size() == 2) begin
                    first  = done_q.pop_front();
                    second = done_q.pop_front();
                    check_src(first, line_pkg::REQ_DCACHE);
                    check_src(second, line_pkg::REQ_ICACHE);
                end
                i++;
            end else begin
                apply_rows(rows[i], rows[i], 1'b0);
            end
        end
        $display("errors: data %0d, order %0d, timeouts %0d", data_errs, order_errs, timeouts);
        if (data_errs == 0 && order_errs == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : mem_subsystem_tb
